// ==== build.f ====
+incdir+source
source/cheat_pkg.sv
source/snes_bus_if.sv
source/cheat_slots.sv
source/cpu_push_detect.sv
source/vector_hook.sv
source/snescmd_regs.sv
source/cheat_response.sv
source/cheat_top.sv
dv/cheat_properties.sv
dv/cheat_tb.sv

// ==== dv/cheat_properties.sv ====
`default_nettype none

module cheat_properties (
  input wire       clk,
  input wire       SNES_reset_strobe,
  input wire       snescmd_unlock,
  input wire       cheat_hit,
  input wire [1:0] reset_unlock
);

  timeunit 1ns;
  timeprecision 100ps;

  // count of failed assertions
  int assert_failures = 0;

  // window starts locked
  property unlock_low_after_reset;
    @(posedge clk) SNES_reset_strobe |=> !snescmd_unlock;
  endproperty

  // reset vector patch only counts down
  property reset_unlock_no_rise;
    @(posedge clk) disable iff (SNES_reset_strobe)
      reset_unlock <= $past(reset_unlock);
  endproperty

  property hit_known;
    @(posedge clk) disable iff (SNES_reset_strobe)
      !$isunknown(cheat_hit);
  endproperty

  unlock_low_a: assert property (unlock_low_after_reset) else begin
    assert_failures++;
    $error("snescmd_unlock high in the cycle after reset");
  end

  reset_unlock_a: assert property (reset_unlock_no_rise) else begin
    assert_failures++;
    $error("reset_unlock increased outside reset");
  end

  hit_known_a: assert property (hit_known) else begin
    assert_failures++;
    $error("cheat_hit is unknown");
  end

endmodule

bind cheat_top cheat_properties u_props (
  .clk               (clk),
  .SNES_reset_strobe (SNES_reset_strobe),
  .snescmd_unlock    (snescmd_unlock),
  .cheat_hit         (cheat_hit),
  .reset_unlock      (reset_unlock)
);

`default_nettype wire

// ==== dv/cheat_tb.sv ====
`default_nettype none

`include "cheat_cfg.svh"

module cheat_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam cheat_pkg::snes_addr_t IDLE_ADDR = 24'h008000;
  localparam cheat_pkg::snes_addr_t FREE_ADDR = 24'h123456;

  logic                  clk = 1'b0;
  logic                  SNES_reset_strobe;
  cheat_pkg::pa_addr_t   snes_pa;
  cheat_pkg::snes_addr_t snes_addr;
  cheat_pkg::snes_byte_t snes_data;
  logic                  snes_wr_strobe;
  logic                  snes_rd_strobe;
  logic                  snes_cycle_start;
  logic                  snes_ajr;
  logic                  pad_latch;
  cheat_pkg::slot_idx_t  pgm_idx;
  logic                  pgm_we;
  cheat_pkg::pgm_word_t  pgm_in;
  cheat_pkg::snes_byte_t data_out;
  logic                  cheat_hit;
  logic                  snescmd_unlock;

  // reference model state
  cheat_pkg::snes_addr_t m_slot_addr [`CHEAT_SLOTS];
  cheat_pkg::snes_byte_t m_slot_data [`CHEAT_SLOTS];
  cheat_pkg::slot_mask_t m_mask;
  logic [5:0]            m_flags;
  cheat_pkg::pad_word_t  m_pad;
  cheat_pkg::snes_byte_t m_retvec;
  int                    m_reset_unlock;
  int                    m_vector_unlock;
  int                    m_unlock;  // 0 locked, 1 open, 2 counting down
  int                    m_release_cnt;
  int                    m_push;
  cheat_pkg::pa_addr_t   m_last_pa;
  int                    m_sync_wait;
  logic                  m_synced;

  // expected values handed to the checker
  logic                  check_req = 1'b0;
  cheat_pkg::snes_addr_t check_addr;
  cheat_pkg::snes_byte_t exp_data;
  logic                  exp_hit;
  logic                  exp_unlock;

  cheat_pkg::snes_addr_t rnd_addr [`CHEAT_SLOTS];
  cheat_pkg::snes_byte_t rnd_data [`CHEAT_SLOTS];

  cheat_top UUT (.*);

  always #2 clk = ~clk;

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  task automatic reset_model();
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      m_slot_addr[i] = '0;
      m_slot_data[i] = '0;
    end
    m_mask          = '0;
    m_flags         = '0;
    m_pad           = '0;
    m_retvec        = '0;
    m_reset_unlock  = 2;
    m_vector_unlock = 0;
    m_unlock        = 0;
    m_release_cnt   = 0;
    m_push          = 0;
    m_last_pa       = '0;
    m_sync_wait     = 2;
    m_synced        = 1'b0;
  endtask

  // start+select with L+R is the only combo driven, other words are off the table
  function automatic cheat_pkg::snes_byte_t pad_code(input cheat_pkg::pad_word_t pad);
    return (pad == 16'h3030) ? 8'h80 : 8'h00;
  endfunction

  // {cheat_hit, data_out} for a read of addr in the current state
  function automatic logic [8:0] expect_read(input cheat_pkg::snes_addr_t addr);
    cheat_pkg::snes_byte_t data;
    logic                  hit;
    logic                  slot_hit;
    logic                  win;
    logic                  nmi_vec;
    logic                  rst_vec;
    data     = `FILL_BYTE;
    slot_hit = 1'b0;
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      if (!slot_hit && m_mask[i] && m_slot_addr[i] == addr) begin
        slot_hit = 1'b1;
        data     = m_slot_data[i];
      end
    end
    if (!slot_hit) begin
      if (addr == `NMI_VEC_ADDR || addr == `IRQ_VEC_ADDR) begin
        data = `VEC_HOOK_BYTE;
      end else if (addr == `RST_VEC_ADDR) begin
        data = `RST_HOOK_BYTE;
      end else if (addr == `NMICMD_ADDR) begin
        data = pad_code(m_pad);
      end else if (addr == `RETVEC_ADDR) begin
        data = m_retvec;
      end
    end
    win     = addr == `NMICMD_ADDR || addr == `RETVEC_ADDR ||
              addr == `BRANCH1_ADDR || addr == `BRANCH2_ADDR;
    nmi_vec = addr == `NMI_VEC_ADDR || addr == `NMI_VEC_ADDR + 24'd1;
    rst_vec = addr == `RST_VEC_ADDR || addr == `RST_VEC_ADDR + 24'd1;
    // irq never wins the auto select in this short run
    hit = (m_flags[0] && slot_hit) ||
          (m_reset_unlock != 0 && rst_vec) ||
          (m_unlock != 0 && m_synced && win) ||
          (m_synced && m_vector_unlock != 0 && m_flags[1] && nmi_vec);
    return {hit, data};
  endfunction

  // state after one bus cycle
  task automatic advance_model(input cheat_pkg::snes_addr_t addr, input logic is_write,
                               input cheat_pkg::pa_addr_t pa,
                               input cheat_pkg::snes_byte_t data);
    logic hook;
    logic rst_open;
    logic release_wr;
    logic cmd_wr;
    hook       = !is_write && m_push == 4 && m_synced && m_flags[1] &&
                 addr == `NMI_VEC_ADDR;
    rst_open   = !is_write && addr == `RST_VEC_ADDR && m_reset_unlock != 0;
    release_wr = is_write && m_unlock != 0 && addr == `RELEASE_ADDR;
    cmd_wr     = is_write && m_unlock != 0 && addr == `SNESCMD_BASE;
    if (!is_write) begin
      if (hook) begin
        m_vector_unlock = 3;
        m_retvec        = addr[7:0];
      end else if (m_vector_unlock != 0) begin
        m_vector_unlock--;
      end
    end
    if ((addr == `RST_VEC_ADDR || addr == `RST_VEC_ADDR + 24'd1) && m_reset_unlock != 0) begin
      m_reset_unlock--;
    end
    if (m_unlock == 0) begin
      if (hook || rst_open) begin
        m_unlock = 1;
      end
    end else if (release_wr) begin
      m_unlock      = 2;
      m_release_cnt = `UNLOCK_RELEASE;
    end else if (m_unlock == 2) begin
      if (m_release_cnt != 0) begin
        m_release_cnt--;
      end else begin
        m_unlock = 0;
      end
    end
    // stack push pattern
    if (is_write) begin
      if (m_push == 0 || pa == m_last_pa - 8'd1) begin
        m_push = (m_push + 1) % 8;
      end else begin
        m_push = 0;
      end
      m_last_pa = pa;
    end else begin
      m_push = 0;
    end
    // hold-off never used, so the hook stays enabled
    if (addr >= `NMI_VEC_ADDR && addr <= `IRQ_VEC_ADDR + 24'd1) begin
      m_sync_wait = 2;
    end else if (m_sync_wait != 0) begin
      m_sync_wait--;
    end else begin
      m_synced = 1'b1;
    end
    if (cmd_wr) begin
      case (data)
        8'h82: m_flags[0] = 1'b1;
        8'h83: m_flags[0] = 1'b0;
        8'h84: begin
          m_flags[1] = 1'b0;
          m_flags[2] = 1'b0;
        end
        default: begin
        end
      endcase
    end
    if (is_write && addr == `PAD_LO_ADDR) begin
      m_pad[7:0] = data;
    end
    if (is_write && addr == `PAD_HI_ADDR) begin
      m_pad[15:8] = data;
    end
  endtask

  //////////////////////////////
  // bus and programming port
  //////////////////////////////

  task automatic bus_read(input cheat_pkg::snes_addr_t addr);
    logic [8:0] expected;
    @(negedge clk);
    snes_addr        = addr;
    snes_rd_strobe   = 1'b1;
    snes_cycle_start = 1'b1;
    expected   = expect_read(addr);
    check_addr = addr;
    exp_data   = expected[7:0];
    exp_hit    = expected[8];
    exp_unlock = m_unlock != 0;
    check_req  = 1'b1;
    advance_model(addr, 1'b0, snes_pa, 8'h00);
    @(negedge clk);
    snes_rd_strobe   = 1'b0;
    snes_cycle_start = 1'b0;
  endtask

  task automatic bus_write(input cheat_pkg::snes_addr_t addr,
                           input cheat_pkg::snes_byte_t data);
    @(negedge clk);
    snes_addr        = addr;
    snes_pa          = addr[7:0];
    snes_data        = data;
    snes_wr_strobe   = 1'b1;
    snes_cycle_start = 1'b1;
    advance_model(addr, 1'b1, addr[7:0], data);
    @(negedge clk);
    snes_wr_strobe   = 1'b0;
    snes_cycle_start = 1'b0;
  endtask

  task automatic pgm_write(input cheat_pkg::slot_idx_t idx, input cheat_pkg::pgm_word_t word);
    @(negedge clk);
    pgm_idx = idx;
    pgm_in  = word;
    pgm_we  = 1'b1;
    if (idx < `CHEAT_SLOTS) begin
      m_slot_addr[idx] = word[31:8];
      m_slot_data[idx] = word[7:0];
    end else if (idx == `CHEAT_SLOTS) begin
      m_mask = word[`CHEAT_SLOTS-1:0];
    end else begin
      m_flags = (m_flags & ~word[13:8]) | word[5:0];
    end
    @(negedge clk);
    pgm_we = 1'b0;
  endtask

  // quiet cycles, interrupt push, then the nmi vector fetch
  task automatic nmi_sequence();
    repeat (3) bus_read(IDLE_ADDR);
    for (int k = 0; k < 4; k++) begin
      bus_write(24'h0001FF - 24'(k), 8'($urandom));
    end
    bus_read(`NMI_VEC_ADDR);
    bus_read(`NMI_VEC_ADDR + 24'd1);
  endtask

  // release write, then count cycle_starts until the window locks again
  task automatic relock_window();
    int waited;
    bus_write(`RELEASE_ADDR, 8'h00);
    waited = 0;
    while (snescmd_unlock && waited < 200) begin
      bus_read(IDLE_ADDR);
      waited++;
    end
    if (snescmd_unlock) begin
      abort_run("window stayed unlocked long after the release write");
    end else begin
      compare_value("cycles to relock", waited, `UNLOCK_RELEASE + 1);
    end
  endtask

  // compares every read against the reference
  always begin
    @(negedge clk);
    #1;
    if (check_req) begin
      compare_value($sformatf("data_out at %06h", check_addr), data_out, exp_data);
      compare_value($sformatf("cheat_hit at %06h", check_addr), cheat_hit, exp_hit);
      compare_value("snescmd_unlock", snescmd_unlock, exp_unlock);
      check_req = 1'b0;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    void'($urandom(32'h83be6f78));
    SNES_reset_strobe = 1'b1;
    snes_pa           = '0;
    snes_addr         = IDLE_ADDR;
    snes_data         = '0;
    snes_wr_strobe    = 1'b0;
    snes_rd_strobe    = 1'b0;
    snes_cycle_start  = 1'b0;
    snes_ajr          = 1'b0;
    pad_latch         = 1'b0;
    pgm_idx           = '0;
    pgm_we            = 1'b0;
    pgm_in            = '0;
    reset_model();
    repeat (10) @(negedge clk);
    SNES_reset_strobe = 1'b0;

    // reset vector, patched once
    bus_read(IDLE_ADDR);
    bus_read(`RST_VEC_ADDR);
    bus_read(`RST_VEC_ADDR + 24'd1);
    bus_read(`RST_VEC_ADDR);
    bus_read(`RST_VEC_ADDR + 24'd1);

    // patch slots, slot 4 shadowed by slot 1, slot 5 masked
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      rnd_addr[i] = {1'b1, 23'($urandom)};
      rnd_data[i] = 8'($urandom);
    end
    rnd_addr[4] = rnd_addr[1];
    rnd_data[4] = ~rnd_data[1];
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      pgm_write(cheat_pkg::slot_idx_t'(i), {rnd_addr[i], rnd_data[i]});
    end
    pgm_write(3'd6, 32'h0000_001F);
    pgm_write(3'd7, 32'h0000_0001);
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      bus_read(rnd_addr[i]);
    end
    bus_read(FREE_ADDR);

    // lock the window opened by the reset fetch
    relock_window();

    // nmi hook
    pgm_write(3'd7, 32'h0000_0002);
    nmi_sequence();
    compare_value("snescmd_unlock", snescmd_unlock, 32'd1);
    bus_read(`RETVEC_ADDR);

    // commands through the window
    bus_write(`SNESCMD_BASE, 8'h83);
    bus_read(rnd_addr[0]);
    bus_read(rnd_addr[2]);
    bus_write(`SNESCMD_BASE, 8'h82);
    bus_read(rnd_addr[0]);
    bus_read(rnd_addr[2]);
    bus_write(`SNESCMD_BASE, 8'h84);
    nmi_sequence();

    // controller combos
    bus_write(`PAD_LO_ADDR, 8'h30);
    bus_write(`PAD_HI_ADDR, 8'h30);
    bus_read(`NMICMD_ADDR);
    bus_write(`PAD_LO_ADDR, 8'h34);
    bus_write(`PAD_HI_ADDR, 8'h12);
    bus_read(`NMICMD_ADDR);
    bus_write(`PAD_LO_ADDR, 8'hFF);
    bus_write(`PAD_HI_ADDR, 8'hFF);
    bus_read(`NMICMD_ADDR);

    // window release countdown
    relock_window();
    bus_read(`NMICMD_ADDR);

    if (UUT.u_props.assert_failures != 0) begin
      abort_run("bound assertions fired during the run");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== source/cheat_cfg.svh ====
`ifndef CHEAT_CFG_SVH
`define CHEAT_CFG_SVH

//////////////////////////////
// slots and timing
//////////////////////////////

`define CHEAT_SLOTS     6
// about 10 s of hold-off at the fabric clock
`define HOOK_HOLDOFF    960000000
`define USAGE_WINDOW    2097152
`define UNLOCK_RELEASE  72

//////////////////////////////
// command window map
//////////////////////////////

`define SNESCMD_BASE    24'h002A00
`define PAD_LO_ADDR     24'h002BF0
`define PAD_HI_ADDR     24'h002BF1
`define NMICMD_ADDR     24'h002BF2
`define RELEASE_ADDR    24'h002BFD
`define RETVEC_ADDR     24'h002A5B
`define BRANCH1_ADDR    24'h002A6D
`define BRANCH2_ADDR    24'h002A1F

// cpu vectors, low byte of each
`define NMI_VEC_ADDR    24'h00FFEA
`define IRQ_VEC_ADDR    24'h00FFEE
`define RST_VEC_ADDR    24'h00FFFC

// bytes served on hooked fetches
`define VEC_HOOK_BYTE   8'h04
`define RST_HOOK_BYTE   8'h6F
`define FILL_BYTE       8'h2A

`endif

// ==== source/cheat_pkg.sv ====
`default_nettype none

`include "cheat_cfg.svh"

package cheat_pkg;

  typedef logic [23:0]             snes_addr_t;
  typedef logic [7:0]              snes_byte_t;
  typedef logic [7:0]              pa_addr_t;
  typedef logic [31:0]             pgm_word_t;
  typedef logic [2:0]              slot_idx_t;
  typedef logic [`CHEAT_SLOTS-1:0] slot_mask_t;
  typedef logic [15:0]             pad_word_t;

  // codes written by the game into the command window
  typedef enum logic [7:0] {
    CMD_CHEAT_ON  = 8'h82,
    CMD_CHEAT_OFF = 8'h83,
    CMD_HOOK_OFF  = 8'h84,
    CMD_HOLDOFF   = 8'h85
  } cmd_code_t;

  // window unlock lifecycle
  typedef enum logic [1:0] {
    UNL_IDLE,
    UNL_OPEN,
    UNL_RELEASE
  } unlock_state_t;

endpackage

`default_nettype wire

// ==== source/cheat_response.sv ====
`default_nettype none

`include "cheat_cfg.svh"

module cheat_response (
  snes_bus_if.mon                     bus,
  input  wire cheat_pkg::slot_mask_t  match_bits,
  input  wire cheat_pkg::snes_byte_t  patch_data,
  input  wire                         nmicmd_sel,
  input  wire                         retvec_sel,
  input  wire                         br1_sel,
  input  wire                         br2_sel,
  input  wire cheat_pkg::snes_byte_t  nmicmd,
  input  wire cheat_pkg::snes_byte_t  branch1_offset,
  input  wire cheat_pkg::snes_byte_t  branch2_offset,
  input  wire cheat_pkg::snes_byte_t  return_vector,
  input  wire [1:0]                   vector_unlock,
  input  wire [1:0]                   reset_unlock,
  input  wire                         snescmd_unlock,
  input  wire                         hook_sync,
  input  wire                         auto_nmi_sync,
  input  wire                         auto_irq_sync,
  input  wire                         nmi_enable,
  input  wire                         irq_enable,
  input  wire                         cheat_enable,
  output cheat_pkg::snes_byte_t       data_out,
  output logic                        cheat_hit
);

  logic nmi_match;
  logic irq_match;
  logic rst_match;
  logic win_sel;

  assign nmi_match = bus.addr == `NMI_VEC_ADDR || bus.addr == `NMI_VEC_ADDR + 24'd1;
  assign irq_match = bus.addr == `IRQ_VEC_ADDR || bus.addr == `IRQ_VEC_ADDR + 24'd1;
  assign rst_match = bus.addr == `RST_VEC_ADDR || bus.addr == `RST_VEC_ADDR + 24'd1;
  assign win_sel   = nmicmd_sel || retvec_sel || br1_sel || br2_sel;

  // vector fetches jump to $2A04 (hooks) or $2A6F (reset)
  always_comb begin
    if (|match_bits) begin
      data_out = patch_data;
    end else if (bus.addr == `NMI_VEC_ADDR || bus.addr == `IRQ_VEC_ADDR) begin
      data_out = `VEC_HOOK_BYTE;
    end else if (bus.addr == `RST_VEC_ADDR) begin
      data_out = `RST_HOOK_BYTE;
    end else if (nmicmd_sel) begin
      data_out = nmicmd;
    end else if (retvec_sel) begin
      data_out = return_vector;
    end else if (br1_sel) begin
      data_out = branch1_offset;
    end else if (br2_sel) begin
      data_out = branch2_offset;
    end else begin
      data_out = `FILL_BYTE;
    end
  end

  assign cheat_hit = (cheat_enable && |match_bits)
                   || (reset_unlock != 2'd0 && rst_match)
                   || (snescmd_unlock && hook_sync && win_sel)
                   || (hook_sync && vector_unlock != 2'd0 &&
                       ((auto_nmi_sync && nmi_enable && nmi_match) ||
                        (auto_irq_sync && irq_enable && irq_match)));

endmodule

`default_nettype wire

// ==== source/cheat_slots.sv ====
`default_nettype none

`include "cheat_cfg.svh"

module cheat_slots (
  input  wire                        clk,
  input  wire                        SNES_reset_strobe,
  snes_bus_if.mon                    bus,
  input  wire cheat_pkg::slot_idx_t  pgm_idx,
  input  wire                        pgm_we,
  input  wire cheat_pkg::pgm_word_t  pgm_in,
  output cheat_pkg::slot_mask_t      match_bits,
  output cheat_pkg::snes_byte_t      patch_data
);

  cheat_pkg::snes_addr_t slot_addr [`CHEAT_SLOTS];
  cheat_pkg::snes_byte_t slot_data [`CHEAT_SLOTS];
  cheat_pkg::slot_mask_t slot_mask;

  // slot contents, address in the upper three bytes
  always_ff @(posedge clk) begin
    if (pgm_we && pgm_idx < `CHEAT_SLOTS) begin
      slot_addr[pgm_idx] <= pgm_in[31:8];
      slot_data[pgm_idx] <= pgm_in[7:0];
    end
  end

  // index just past the slots loads the mask
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      slot_mask <= '0;
    end else if (pgm_we && pgm_idx == `CHEAT_SLOTS) begin
      slot_mask <= pgm_in[`CHEAT_SLOTS-1:0];
    end
  end

  always_comb begin
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      match_bits[i] = slot_mask[i] && (bus.addr == slot_addr[i]);
    end
  end

  // walk down so the lowest slot wins
  always_comb begin
    patch_data = '0;
    for (int i = `CHEAT_SLOTS - 1; i >= 0; i--) begin
      if (match_bits[i]) begin
        patch_data = slot_data[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/cheat_top.sv ====
`default_nettype none

module cheat_top (
  input  wire                        clk,
  input  wire                        SNES_reset_strobe,
  input  wire cheat_pkg::pa_addr_t   snes_pa,
  input  wire cheat_pkg::snes_addr_t snes_addr,
  input  wire cheat_pkg::snes_byte_t snes_data,
  input  wire                        snes_wr_strobe,
  input  wire                        snes_rd_strobe,
  input  wire                        snes_cycle_start,
  input  wire                        snes_ajr,
  input  wire                        pad_latch,
  input  wire cheat_pkg::slot_idx_t  pgm_idx,
  input  wire                        pgm_we,
  input  wire cheat_pkg::pgm_word_t  pgm_in,
  output cheat_pkg::snes_byte_t      data_out,
  output logic                       cheat_hit,
  output logic                       snescmd_unlock
);

  cheat_pkg::slot_mask_t match_bits;
  cheat_pkg::snes_byte_t patch_data;
  logic [2:0]            push_cnt;
  logic                  nmicmd_sel;
  logic                  retvec_sel;
  logic                  br1_sel;
  logic                  br2_sel;
  cheat_pkg::snes_byte_t nmicmd;
  cheat_pkg::snes_byte_t branch1_offset;
  cheat_pkg::snes_byte_t branch2_offset;
  cheat_pkg::snes_byte_t return_vector;
  logic                  cheat_enable;
  logic                  nmi_enable;
  logic                  irq_enable;
  logic                  holdoff_enable;
  logic                  hook_enable;
  logic                  release_strobe;
  logic [1:0]            vector_unlock;
  logic [1:0]            reset_unlock;
  logic                  hook_sync;
  logic                  auto_nmi_sync;
  logic                  auto_irq_sync;

  // bus bundle shared by all blocks
  snes_bus_if bus ();

  assign bus.addr        = snes_addr;
  assign bus.pa          = snes_pa;
  assign bus.data        = snes_data;
  assign bus.wr_strobe   = snes_wr_strobe;
  assign bus.rd_strobe   = snes_rd_strobe;
  assign bus.cycle_start = snes_cycle_start;

  cheat_slots     u_slots    (.*);
  cpu_push_detect u_push     (.*);
  snescmd_regs    u_regs     (.*);
  vector_hook     u_hook     (.*);
  cheat_response  u_response (.*);

endmodule

`default_nettype wire

// ==== source/cpu_push_detect.sv ====
`default_nettype none

module cpu_push_detect (
  input  wire        clk,
  input  wire        SNES_reset_strobe,
  snes_bus_if.mon    bus,
  output logic [2:0] push_cnt
);

  // an interrupt pushes PB, PC and P as four writes to falling stack
  // addresses, mirrored on the B bus so DMA cannot fake the pattern
  cheat_pkg::pa_addr_t next_pa;

  always_ff @(posedge clk) begin
    if (bus.wr_strobe) begin
      if (push_cnt == 3'd0) begin
        next_pa <= bus.pa - 1'b1;
      end else begin
        next_pa <= next_pa - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      push_cnt <= 3'd0;
    end else if (bus.wr_strobe) begin
      if (push_cnt == 3'd0 || bus.pa == next_pa) begin
        push_cnt <= push_cnt + 1'b1;
      end else begin
        push_cnt <= 3'd0;
      end
    end else if (bus.rd_strobe) begin
      push_cnt <= 3'd0;
    end
  end

endmodule

`default_nettype wire

// ==== source/snes_bus_if.sv ====
`default_nettype none

interface snes_bus_if;

  cheat_pkg::snes_addr_t addr;
  cheat_pkg::pa_addr_t   pa;
  cheat_pkg::snes_byte_t data;
  // one clk pulse per access
  logic                  wr_strobe;
  logic                  rd_strobe;
  // one clk pulse per bus cycle
  logic                  cycle_start;

  modport mon (
    input addr,
    input pa,
    input data,
    input wr_strobe,
    input rd_strobe,
    input cycle_start
  );

endinterface

`default_nettype wire

// ==== source/snescmd_regs.sv ====
`default_nettype none

`include "cheat_cfg.svh"

module snescmd_regs (
  input  wire                        clk,
  input  wire                        SNES_reset_strobe,
  snes_bus_if.mon                    bus,
  input  wire                        snescmd_unlock,
  input  wire                        snes_ajr,
  input  wire                        pad_latch,
  input  wire cheat_pkg::slot_idx_t  pgm_idx,
  input  wire                        pgm_we,
  input  wire cheat_pkg::pgm_word_t  pgm_in,
  output logic                       nmicmd_sel,
  output logic                       retvec_sel,
  output logic                       br1_sel,
  output logic                       br2_sel,
  output cheat_pkg::snes_byte_t      nmicmd,
  output cheat_pkg::snes_byte_t      branch1_offset,
  output cheat_pkg::snes_byte_t      branch2_offset,
  output logic                       cheat_enable,
  output logic                       nmi_enable,
  output logic                       irq_enable,
  output logic                       holdoff_enable,
  output logic                       hook_enable,
  output logic                       release_strobe
);

  localparam int HOLD_W = $clog2(`HOOK_HOLDOFF + 1);

  // flag layout on programming index 7
  localparam int F_CHEAT   = 0;
  localparam int F_NMI     = 1;
  localparam int F_IRQ     = 2;
  localparam int F_HOLDOFF = 3;
  localparam int F_BUTTONS = 4;
  localparam int F_WRAM    = 5;

  logic [5:0]           flags;
  logic [HOLD_W-1:0]    holdoff_cnt;
  cheat_pkg::pad_word_t pad_word;
  logic                 cmd_wr;
  logic                 branch_wram;

  assign cmd_wr         = snescmd_unlock && bus.wr_strobe && bus.addr == `SNESCMD_BASE;
  assign release_strobe = snescmd_unlock && bus.wr_strobe && bus.addr == `RELEASE_ADDR;

  assign nmicmd_sel = bus.addr == `NMICMD_ADDR;
  assign retvec_sel = bus.addr == `RETVEC_ADDR;
  assign br1_sel    = bus.addr == `BRANCH1_ADDR;
  assign br2_sel    = bus.addr == `BRANCH2_ADDR;

  assign cheat_enable   = flags[F_CHEAT];
  assign nmi_enable     = flags[F_NMI];
  assign irq_enable     = flags[F_IRQ];
  assign holdoff_enable = flags[F_HOLDOFF];
  assign branch_wram    = flags[F_CHEAT] && flags[F_WRAM];
  assign hook_enable    = holdoff_cnt == '0;

  //////////////////////////////
  // flags and hold-off
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      flags <= '0;
    end else if (cmd_wr) begin
      case (bus.data)
        cheat_pkg::CMD_CHEAT_ON:  flags[F_CHEAT] <= 1'b1;
        cheat_pkg::CMD_CHEAT_OFF: flags[F_CHEAT] <= 1'b0;
        cheat_pkg::CMD_HOOK_OFF: begin
          flags[F_NMI] <= 1'b0;
          flags[F_IRQ] <= 1'b0;
        end
        default: flags <= flags;
      endcase
    end else if (pgm_we && pgm_idx == 3'd7) begin
      // clear mask in bits 13..8, set mask in bits 5..0
      flags <= (flags & ~pgm_in[13:8]) | pgm_in[5:0];
    end
  end

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      holdoff_cnt <= holdoff_enable ? HOLD_W'(`HOOK_HOLDOFF) : '0;
    end else if (cmd_wr && bus.data == cheat_pkg::CMD_HOLDOFF) begin
      holdoff_cnt <= HOLD_W'(`HOOK_HOLDOFF);
    end else if (!hook_enable) begin
      holdoff_cnt <= holdoff_cnt - 1'b1;
    end
  end

  //////////////////////////////
  // pad combos
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      pad_word <= '0;
    end else if (bus.wr_strobe) begin
      if (bus.addr == `PAD_LO_ADDR) begin
        pad_word[7:0] <= bus.data;
      end else if (bus.addr == `PAD_HI_ADDR) begin
        pad_word[15:8] <= bus.data;
      end
    end
  end

  // all combos hold L+R
  always_comb begin
    case (pad_word)
      16'h3030: nmicmd = 8'h80;  // start+select
      16'h2070: nmicmd = 8'h81;  // select+x
      16'h10b0: nmicmd = 8'h82;  // start+a
      16'h9030: nmicmd = 8'h83;  // start+b
      16'h5030: nmicmd = 8'h84;  // start+y
      16'h1070: nmicmd = 8'h85;  // start+x
      default:  nmicmd = 8'h00;
    endcase
  end

  // branch targets inside the window code
  always_comb begin
    if (flags[F_BUTTONS] && snes_ajr && nmicmd != 8'h00) begin
      branch1_offset = 8'h30;
    end else if (flags[F_BUTTONS] && !snes_ajr && !pad_latch) begin
      branch1_offset = 8'h00;
    end else begin
      branch1_offset = branch_wram ? 8'h3a : 8'h3d;
    end
  end

  always_comb begin
    if (nmicmd == 8'h81) begin
      branch2_offset = 8'h12;
    end else begin
      branch2_offset = branch_wram ? 8'h00 : 8'h03;
    end
  end

endmodule

`default_nettype wire

// ==== source/vector_hook.sv ====
`default_nettype none

`include "cheat_cfg.svh"

module vector_hook (
  input  wire                    clk,
  input  wire                    SNES_reset_strobe,
  snes_bus_if.mon                bus,
  input  wire [2:0]              push_cnt,
  input  wire                    nmi_enable,
  input  wire                    irq_enable,
  input  wire                    hook_enable,
  input  wire                    release_strobe,
  output logic                   snescmd_unlock,
  output logic [1:0]             vector_unlock,
  output logic [1:0]             reset_unlock,
  output logic                   hook_sync,
  output logic                   auto_nmi_sync,
  output logic                   auto_irq_sync,
  output cheat_pkg::snes_byte_t  return_vector
);

  localparam int REL_W   = $clog2(`UNLOCK_RELEASE + 1);
  localparam int USAGE_W = $clog2(`USAGE_WINDOW);

  cheat_pkg::unlock_state_t unl_state;
  logic [REL_W-1:0]         release_cnt;
  logic [USAGE_W-1:0]       usage_cnt;
  logic [4:0]               nmi_usage;
  logic [4:0]               irq_usage;
  logic                     auto_nmi;
  logic                     auto_irq;
  logic [1:0]               sync_delay;
  logic                     nmi_fetch;
  logic                     irq_fetch;
  logic                     rst_match;
  logic                     vec_area;
  logic                     hook_fetch;

  assign nmi_fetch = bus.addr == `NMI_VEC_ADDR;
  assign irq_fetch = bus.addr == `IRQ_VEC_ADDR;
  assign rst_match = bus.addr == `RST_VEC_ADDR || bus.addr == `RST_VEC_ADDR + 24'd1;
  assign vec_area  = bus.addr >= `NMI_VEC_ADDR && bus.addr <= `IRQ_VEC_ADDR + 24'd1;

  // vector read straight after a four-write push
  assign hook_fetch = bus.rd_strobe && push_cnt == 3'd4 && hook_sync &&
                      ((auto_nmi_sync && nmi_enable && nmi_fetch) ||
                       (auto_irq_sync && irq_enable && irq_fetch));

  assign snescmd_unlock = unl_state != cheat_pkg::UNL_IDLE;

  //////////////////////////////
  // vector visibility
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      vector_unlock <= 2'd0;
    end else if (bus.rd_strobe) begin
      if (hook_fetch) begin
        vector_unlock <= 2'd3;
      end else if (vector_unlock != 2'd0) begin
        vector_unlock <= vector_unlock - 1'b1;
      end
    end
  end

  // reset vector patched for the first fetch only
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      reset_unlock <= 2'd2;
    end else if (bus.cycle_start && rst_match && reset_unlock != 2'd0) begin
      reset_unlock <= reset_unlock - 1'b1;
    end
  end

  // where the hook came from, for the exit jump
  always_ff @(posedge clk) begin
    if (hook_fetch) begin
      return_vector <= bus.addr[7:0];
    end
  end

  //////////////////////////////
  // window unlock
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      unl_state   <= cheat_pkg::UNL_IDLE;
      release_cnt <= '0;
    end else begin
      case (unl_state)
        cheat_pkg::UNL_IDLE: begin
          if (hook_fetch ||
              (bus.rd_strobe && bus.addr == `RST_VEC_ADDR && reset_unlock != 2'd0)) begin
            unl_state <= cheat_pkg::UNL_OPEN;
          end
        end
        cheat_pkg::UNL_OPEN: begin
          if (release_strobe) begin
            unl_state   <= cheat_pkg::UNL_RELEASE;
            release_cnt <= REL_W'(`UNLOCK_RELEASE);
          end
        end
        cheat_pkg::UNL_RELEASE: begin
          // leave the game time to jump back out of the window
          if (release_strobe) begin
            release_cnt <= REL_W'(`UNLOCK_RELEASE);
          end else if (bus.cycle_start) begin
            if (release_cnt != '0) begin
              release_cnt <= release_cnt - 1'b1;
            end else begin
              unl_state <= cheat_pkg::UNL_IDLE;
            end
          end
        end
        default: unl_state <= cheat_pkg::UNL_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // nmi / irq auto select
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      usage_cnt <= USAGE_W'(`USAGE_WINDOW - 1);
      nmi_usage <= '0;
      irq_usage <= '0;
      auto_nmi  <= 1'b1;
      auto_irq  <= 1'b0;
    end else if (usage_cnt == '0) begin
      usage_cnt <= USAGE_W'(`USAGE_WINDOW - 1);
      nmi_usage <= '0;
      irq_usage <= '0;
      // irq only when the game never touched the nmi vector
      auto_irq  <= irq_usage != '0 && nmi_usage == '0;
      auto_nmi  <= !(irq_usage != '0 && nmi_usage == '0);
    end else begin
      usage_cnt <= usage_cnt - 1'b1;
      if (bus.cycle_start && nmi_fetch && !(&nmi_usage)) begin
        nmi_usage <= nmi_usage + 1'b1;
      end
      if (bus.cycle_start && irq_fetch && !(&irq_usage)) begin
        irq_usage <= irq_usage + 1'b1;
      end
    end
  end

  // no switching while a vector is mid-fetch
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      sync_delay    <= 2'd2;
      hook_sync     <= 1'b0;
      auto_nmi_sync <= 1'b0;
      auto_irq_sync <= 1'b0;
    end else if (bus.cycle_start) begin
      if (vec_area) begin
        sync_delay <= 2'd2;
      end else if (sync_delay != 2'd0) begin
        sync_delay <= sync_delay - 1'b1;
      end else begin
        hook_sync     <= hook_enable;
        auto_nmi_sync <= auto_nmi;
        auto_irq_sync <= auto_irq;
      end
    end
  end

endmodule

`default_nettype wire
